/* src/exec_pkg.sv */
/*
 * Execution stage shared definitions
 * Operand, address, register index and issue number widths,
 * the opcode encoding, the lane count and the load/store test
 * used by the dispatcher, the units and the write-back selector
 */
package exec_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////
	localparam int DATA_W	= 32;				// Operand and memory word
	localparam int ADDR_W	= 16;				// Word address
	localparam int INDEX_W	= 4;				// Destination register index
	localparam int ISSUE_W	= 6;				// Wrapping issue number
	localparam int SHAMT_W	= 5;				// Shift amount taken from operand b

	////////////////////////////////////////////////////////////
	// Unit layout
	////////////////////////////////////////////////////////////
	localparam int LANES	= 2;				// Load/store lanes
	localparam int LANE_W	= $clog2(LANES);	// Low address bits picking the lane
	localparam int NSRC		= LANES + 1;		// Write-back sources
	localparam int SRC_ALU	= 0;				// Lanes follow at 1 + lane

	typedef logic [DATA_W-1:0]	data_t;
	typedef logic [ADDR_W-1:0]	addr_t;
	typedef logic [INDEX_W-1:0]	index_t;
	typedef logic [ISSUE_W-1:0]	issue_no_t;

	typedef enum logic [2:0] {
		OP_ADD		= 3'd0,
		OP_SUB		= 3'd1,
		OP_AND		= 3'd2,
		OP_XOR		= 3'd3,
		OP_SHL		= 3'd4,
		OP_LOAD		= 3'd5,
		OP_STORE	= 3'd6
	} op_t;

	// Memory commands go to a lane, the rest to the ALU
	function automatic logic is_ldst(input op_t op);
		return (op == OP_LOAD) || (op == OP_STORE);
	endfunction

endpackage

/* src/exec_dispatch.sv */
/*
 * Command dispatcher
 * Numbers each accepted command, registers it and pulses the start
 * line of the ALU or of the load/store lane picked by the address.
 * ready follows the free flag of the target unit.
 */
`timescale 1ns/1ns

module exec_dispatch (
	input	logic					clock,
	input	logic					rst,
	input	logic					req,
	input	exec_pkg::op_t			op,
	input	exec_pkg::index_t		dst,
	input	exec_pkg::data_t		src_a,
	input	exec_pkg::data_t		src_b,
	input	logic					alu_free,
	input	logic					lane_free	[exec_pkg::LANES],
	output	logic					ready,
	output	logic					alu_start,
	output	logic					lane_start	[exec_pkg::LANES],
	output	exec_pkg::op_t			d_op,
	output	exec_pkg::index_t		d_dst,
	output	exec_pkg::data_t		d_a,
	output	exec_pkg::data_t		d_b,
	output	exec_pkg::issue_no_t	d_issue_no,
	output	exec_pkg::issue_no_t	next_issue_no
);

	logic							accept;
	logic							ldst;
	logic [exec_pkg::LANE_W-1:0]	lane_sel;
	exec_pkg::issue_no_t			issue_cnt;
	logic [exec_pkg::LANES:0]		start_vec;

	assign ldst		= exec_pkg::is_ldst(op);
	assign lane_sel	= src_a[exec_pkg::LANE_W-1:0];	// Word address bit 0
	assign ready	= ldst ? lane_free[lane_sel] : alu_free;
	assign accept	= req & ready;

	assign next_issue_no = issue_cnt;

	always_ff @(posedge clock) begin
		if (rst) begin
			alu_start <= 1'b0;
			for (int l = 0; l < exec_pkg::LANES; l++)
				lane_start[l] <= 1'b0;
			issue_cnt <= '0;
		end else begin
			alu_start <= accept & ~ldst;
			for (int l = 0; l < exec_pkg::LANES; l++)
				lane_start[l] <= accept & ldst & (int'(lane_sel) == l);
			if (accept)
				issue_cnt <= issue_cnt + 1'b1;		// Wraps at 64
		end
	end

	// Dispatch register holds the command payload
	always_ff @(posedge clock) begin
		if (accept) begin
			d_op		<= op;
			d_dst		<= dst;
			d_a			<= src_a;
			d_b			<= src_b;
			d_issue_no	<= issue_cnt;
		end
	end

	always_comb begin
		start_vec[0] = alu_start;
		for (int l = 0; l < exec_pkg::LANES; l++)
			start_vec[l + 1] = lane_start[l];
	end

	a_one_start: assert property (@(posedge clock) disable iff (rst) $onehot0(start_vec))
		else $error("more than one unit started in a cycle");

endmodule

/* src/exec_alu.sv */
/*
 * Two-stage integer ALU
 * Stage one computes add, sub, and, xor or shift left from the
 * dispatched operands. Stage two holds the result with its dst and
 * issue number until the write-back selector grants it.
 */
`timescale 1ns/1ns

module exec_alu (
	input	logic					clock,
	input	logic					rst,
	input	logic					start,
	input	exec_pkg::op_t			op,
	input	exec_pkg::index_t		dst,
	input	exec_pkg::data_t		a,
	input	exec_pkg::data_t		b,
	input	exec_pkg::issue_no_t	issue_no,
	input	logic					grant,
	output	logic					free,
	output	logic					res_valid,
	output	exec_pkg::index_t		res_dst,
	output	exec_pkg::data_t		res_data,
	output	exec_pkg::issue_no_t	res_issue_no
);

	logic					s1_valid;
	exec_pkg::data_t		s1_data;
	exec_pkg::index_t		s1_dst;
	exec_pkg::issue_no_t	s1_issue_no;
	logic					s2_valid;
	exec_pkg::data_t		s2_data;
	exec_pkg::index_t		s2_dst;
	exec_pkg::issue_no_t	s2_issue_no;

	exec_pkg::data_t		alu_out;
	logic					adv2;
	logic					take1;
	logic					s1_valid_nxt;
	logic					s2_valid_nxt;

	always_comb begin
		case (op)
			exec_pkg::OP_ADD:	alu_out = a + b;
			exec_pkg::OP_SUB:	alu_out = a - b;
			exec_pkg::OP_AND:	alu_out = a & b;
			exec_pkg::OP_XOR:	alu_out = a ^ b;
			exec_pkg::OP_SHL:	alu_out = a << b[exec_pkg::SHAMT_W-1:0];
			default:			alu_out = '0;		// Memory ops never start here
		endcase
	end

	////////////////////////////////////////////////////////////
	// Pipeline advance
	////////////////////////////////////////////////////////////
	assign adv2			= s1_valid & (~s2_valid | grant);	// Stage one moves up
	assign take1		= start & (~s1_valid | adv2);
	assign s1_valid_nxt	= take1 | (s1_valid & ~adv2);
	assign s2_valid_nxt	= adv2 | (s2_valid & ~grant);

	// A start next cycle must always find room in stage one
	assign free = ~(s1_valid_nxt & s2_valid_nxt);

	always_ff @(posedge clock) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= s1_valid_nxt;
			s2_valid <= s2_valid_nxt;
		end
	end

	always_ff @(posedge clock) begin
		if (take1) begin
			s1_data		<= alu_out;
			s1_dst		<= dst;
			s1_issue_no	<= issue_no;
		end
		if (adv2) begin
			s2_data		<= s1_data;
			s2_dst		<= s1_dst;
			s2_issue_no	<= s1_issue_no;
		end
	end

	assign res_valid	= s2_valid;
	assign res_dst		= s2_dst;
	assign res_data		= s2_data;
	assign res_issue_no	= s2_issue_no;

	a_hold_stable: assert property (@(posedge clock) disable iff (rst)
		s2_valid && !grant |=> s2_valid && $stable(s2_data) && $stable(s2_issue_no))
		else $error("ALU result changed while waiting for grant");

endmodule

/* src/ldst_lane.sv */
/*
 * Load/store lane
 * Runs one Wishbone classic cycle per command on its memory bank.
 * A load keeps the read data with its dst and issue number until
 * the write-back selector grants it; a store ends at ack.
 */
`timescale 1ns/1ns

module ldst_lane (
	input	logic					clock,
	input	logic					rst,
	input	logic					start,
	input	exec_pkg::op_t			op,
	input	exec_pkg::index_t		dst,
	input	exec_pkg::data_t		a,
	input	exec_pkg::data_t		b,
	input	exec_pkg::issue_no_t	issue_no,
	input	logic					grant,
	input	exec_pkg::data_t		wb_dat_r,
	input	logic					wb_ack,
	output	logic					free,
	output	logic					res_valid,
	output	exec_pkg::index_t		res_dst,
	output	exec_pkg::data_t		res_data,
	output	exec_pkg::issue_no_t	res_issue_no,
	output	logic					wb_cyc,
	output	logic					wb_stb,
	output	logic					wb_we,
	output	exec_pkg::addr_t		wb_adr,
	output	exec_pkg::data_t		wb_dat_w
);

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		HOLD
	} lane_state_t;

	lane_state_t			state;
	logic					launch;
	logic					done_ack;

	exec_pkg::addr_t		adr_q;
	exec_pkg::data_t		dat_w_q;
	logic					we_q;
	exec_pkg::index_t		dst_q;
	exec_pkg::issue_no_t	issue_q;
	exec_pkg::data_t		rdata_q;

	assign launch	= (state == IDLE) & start & exec_pkg::is_ldst(op);
	assign done_ack	= (state == ACCESS) & wb_ack;

	////////////////////////////////////////////////////////////
	// Lane FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (launch)
						state <= ACCESS;		// Bus request next cycle
				end
				ACCESS: begin
					if (wb_ack)
						state <= we_q ? IDLE : HOLD;
				end
				HOLD: begin
					if (grant)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Command and result payload
	always_ff @(posedge clock) begin
		if (launch) begin
			adr_q	<= exec_pkg::addr_t'(a);
			dat_w_q	<= b;
			we_q	<= (op == exec_pkg::OP_STORE);
			dst_q	<= dst;
			issue_q	<= issue_no;
		end
		if (done_ack)
			rdata_q <= wb_dat_r;			// Load data lands here
	end

	// Lane can take a start in the next cycle
	assign free = ~start & ((state == IDLE) |
						((state == HOLD) & grant) |
						(done_ack & we_q));

	////////////////////////////////////////////////////////////
	// Wishbone master
	////////////////////////////////////////////////////////////
	assign wb_cyc	= (state == ACCESS);
	assign wb_stb	= (state == ACCESS);
	assign wb_we	= we_q;
	assign wb_adr	= adr_q;
	assign wb_dat_w	= dat_w_q;

	assign res_valid	= (state == HOLD);
	assign res_dst		= dst_q;
	assign res_data		= rdata_q;
	assign res_issue_no	= issue_q;

	a_stb_cyc: assert property (@(posedge clock) disable iff (rst) wb_stb |-> wb_cyc)
		else $error("stb without cyc");

	a_adr_hold: assert property (@(posedge clock) disable iff (rst)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_w)
			&& $stable(wb_we))
		else $error("Wishbone request changed before ack");

endmodule

/* src/wb_select.sv */
/*
 * Write-back selector
 * Ages every waiting result against the next issue number and
 * puts the oldest on the write-back port, lower index on a tie.
 * The winner gets a one-hot grant in the same cycle.
 */
`timescale 1ns/1ns

module wb_select (
	input	logic					valid		[exec_pkg::NSRC],
	input	exec_pkg::index_t		dst			[exec_pkg::NSRC],
	input	exec_pkg::data_t		data		[exec_pkg::NSRC],
	input	exec_pkg::issue_no_t	issue_no	[exec_pkg::NSRC],
	input	exec_pkg::issue_no_t	next_issue_no,
	output	logic					grant		[exec_pkg::NSRC],
	output	logic					wb_valid,
	output	exec_pkg::index_t		wb_dst,
	output	exec_pkg::data_t		wb_data,
	output	exec_pkg::issue_no_t	wb_issue_no
);

	exec_pkg::issue_no_t		age		[exec_pkg::NSRC];
	exec_pkg::issue_no_t		best_age;
	int							win_idx;
	logic [exec_pkg::NSRC-1:0]	grant_vec;

	////////////////////////////////////////////////////////////
	// Oldest-first search
	////////////////////////////////////////////////////////////
	always_comb begin
		best_age	= '0;
		win_idx		= 0;
		wb_valid	= 1'b0;
		for (int i = 0; i < exec_pkg::NSRC; i++) begin
			age[i] = next_issue_no - issue_no[i];	// Modulo 64
			// Strict compare keeps the lower index on a tie
			if (valid[i] && (!wb_valid || (age[i] > best_age))) begin
				best_age	= age[i];
				win_idx		= i;
				wb_valid	= 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < exec_pkg::NSRC; i++) begin
			grant[i]		= wb_valid & (win_idx == i);
			grant_vec[i]	= grant[i];
		end
	end

	assign wb_dst		= dst[win_idx];
	assign wb_data		= data[win_idx];
	assign wb_issue_no	= issue_no[win_idx];

	// One grant for every write-back
	always_comb begin
		a_grant_onehot: assert final ($onehot0(grant_vec) && (wb_valid == (|grant_vec)))
			else $error("write-back grant not one-hot");
	end

endmodule

/* src/exec_unit.sv */
/*
 * Scalar execution stage top
 * Dispatcher, two-stage ALU, a row of identical load/store lanes
 * with their Wishbone ports, and the oldest-first write-back
 * selector. Source 0 is the ALU, source 1 + lane each lane.
 */
`timescale 1ns/1ns

module exec_unit (
	input	logic					clock,
	input	logic					rst,
	input	logic					req,
	input	exec_pkg::op_t			op,
	input	exec_pkg::index_t		dst,
	input	exec_pkg::data_t		src_a,
	input	exec_pkg::data_t		src_b,
	output	logic					ready,
	output	logic					wb_valid,
	output	exec_pkg::index_t		wb_dst,
	output	exec_pkg::data_t		wb_data,
	output	exec_pkg::issue_no_t	wb_issue_no,
	output	logic					wb_cyc		[exec_pkg::LANES],
	output	logic					wb_stb		[exec_pkg::LANES],
	output	logic					wb_we		[exec_pkg::LANES],
	output	exec_pkg::addr_t		wb_adr		[exec_pkg::LANES],
	output	exec_pkg::data_t		wb_dat_w	[exec_pkg::LANES],
	input	exec_pkg::data_t		wb_dat_r	[exec_pkg::LANES],
	input	logic					wb_ack		[exec_pkg::LANES]
);

	logic					alu_start;
	logic					alu_free;
	logic					lane_start		[exec_pkg::LANES];
	logic					lane_free		[exec_pkg::LANES];
	exec_pkg::op_t			d_op;
	exec_pkg::index_t		d_dst;
	exec_pkg::data_t		d_a;
	exec_pkg::data_t		d_b;
	exec_pkg::issue_no_t	d_issue_no;
	exec_pkg::issue_no_t	next_issue_no;

	// Result sources seen by the selector
	logic					src_valid		[exec_pkg::NSRC];
	exec_pkg::index_t		src_dst			[exec_pkg::NSRC];
	exec_pkg::data_t		src_data		[exec_pkg::NSRC];
	exec_pkg::issue_no_t	src_issue_no	[exec_pkg::NSRC];
	logic					src_grant		[exec_pkg::NSRC];

	exec_dispatch u_dispatch (
		.clock(clock), .rst(rst),
		.req(req), .op(op), .dst(dst), .src_a(src_a), .src_b(src_b),
		.alu_free(alu_free), .lane_free(lane_free), .ready(ready),
		.alu_start(alu_start), .lane_start(lane_start),
		.d_op(d_op), .d_dst(d_dst), .d_a(d_a), .d_b(d_b),
		.d_issue_no(d_issue_no), .next_issue_no(next_issue_no)
	);

	exec_alu u_alu (
		.clock(clock), .rst(rst),
		.start(alu_start), .op(d_op), .dst(d_dst), .a(d_a), .b(d_b),
		.issue_no(d_issue_no), .grant(src_grant[exec_pkg::SRC_ALU]), .free(alu_free),
		.res_valid(src_valid[exec_pkg::SRC_ALU]), .res_dst(src_dst[exec_pkg::SRC_ALU]),
		.res_data(src_data[exec_pkg::SRC_ALU]),
		.res_issue_no(src_issue_no[exec_pkg::SRC_ALU])
	);

	////////////////////////////////////////////////////////////
	// Load/store lanes
	////////////////////////////////////////////////////////////
	generate
		for (genvar l = 0; l < exec_pkg::LANES; l++) begin : g_lane
			ldst_lane u_lane (
				.clock(clock), .rst(rst),
				.start(lane_start[l]), .op(d_op), .dst(d_dst), .a(d_a), .b(d_b),
				.issue_no(d_issue_no), .grant(src_grant[1 + l]),
				.wb_dat_r(wb_dat_r[l]), .wb_ack(wb_ack[l]), .free(lane_free[l]),
				.res_valid(src_valid[1 + l]), .res_dst(src_dst[1 + l]),
				.res_data(src_data[1 + l]), .res_issue_no(src_issue_no[1 + l]),
				.wb_cyc(wb_cyc[l]), .wb_stb(wb_stb[l]), .wb_we(wb_we[l]),
				.wb_adr(wb_adr[l]), .wb_dat_w(wb_dat_w[l])
			);
		end
	endgenerate

	wb_select u_select (
		.valid(src_valid), .dst(src_dst), .data(src_data),
		.issue_no(src_issue_no), .next_issue_no(next_issue_no),
		.grant(src_grant), .wb_valid(wb_valid), .wb_dst(wb_dst),
		.wb_data(wb_data), .wb_issue_no(wb_issue_no)
	);

endmodule

/* verif/tb_exec_unit.sv */
/*
 * Execution stage testbench
 * Drives random commands into the execution stage, answers both
 * Wishbone banks with random wait states and checks every
 * write-back against a reference model kept in issue order
 */
`timescale 1ns/1ns

module tb_exec_unit;

	localparam int TOTAL_CMDS	= 328;					// 100 + 48 + 150 + 30 commands
	localparam int CYCLE_LIMIT	= TOTAL_CMDS * 12 + 100;

	logic					clock;
	logic					rst;
	logic					req;
	exec_pkg::op_t			op;
	exec_pkg::index_t		dst;
	exec_pkg::data_t		src_a;
	exec_pkg::data_t		src_b;
	logic					ready;
	logic					wb_valid;
	exec_pkg::index_t		wb_dst;
	exec_pkg::data_t		wb_data;
	exec_pkg::issue_no_t	wb_issue_no;
	logic					wb_cyc		[exec_pkg::LANES];
	logic					wb_stb		[exec_pkg::LANES];
	logic					wb_we		[exec_pkg::LANES];
	exec_pkg::addr_t		wb_adr		[exec_pkg::LANES];
	exec_pkg::data_t		wb_dat_w	[exec_pkg::LANES];
	exec_pkg::data_t		wb_dat_r	[exec_pkg::LANES];
	logic					wb_ack		[exec_pkg::LANES];

	// Memory banks and reference model
	exec_pkg::data_t		bank		[exec_pkg::LANES][65536];
	exec_pkg::data_t		shadow		[65536];		// Memory as seen in issue order
	logic					pend		[64];
	exec_pkg::index_t		exp_dst		[64];
	exec_pkg::data_t		exp_data	[64];
	int						exp_src		[64];
	int						exp_seq		[64];
	int						last_seq	[exec_pkg::NSRC];
	exec_pkg::issue_no_t	issue_cnt;
	int						seq_cnt;
	int						npend;
	int						sent_ldst	[exec_pkg::LANES];
	int						bus_done	[exec_pkg::LANES];
	int						bus_starts	[exec_pkg::LANES];
	int						wait_left	[exec_pkg::LANES];
	logic					active		[exec_pkg::LANES];
	logic					prev_wait	[exec_pkg::LANES];
	logic					prev_cyc	[exec_pkg::LANES];
	exec_pkg::addr_t		prev_adr	[exec_pkg::LANES];
	exec_pkg::data_t		prev_dat	[exec_pkg::LANES];
	logic					load_ready	[exec_pkg::LANES];	// Lane holds a loaded result
	int						load_seq	[exec_pkg::LANES];
	logic					hold_mode;
	int						gap_max;
	int						stalls;
	int						errors;
	int						tests_run;
	int						tests_failed;
	int						cycles;
	string					cur_test;
	int unsigned			stim_state	= 25436;
	int unsigned			mem_state	= 25436;		// Separate stream for the banks

	exec_unit u_dut (
		.clock(clock), .rst(rst), .req(req), .op(op), .dst(dst),
		.src_a(src_a), .src_b(src_b), .ready(ready), .wb_valid(wb_valid),
		.wb_dst(wb_dst), .wb_data(wb_data), .wb_issue_no(wb_issue_no),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic int unsigned lcg_step(inout int unsigned state, input int unsigned range);
		state = state * 32'd1664525 + 32'd1013904223;
		return (state >> 8) % range;
	endfunction

	function automatic int unsigned rnd(input int unsigned range);
		return lcg_step(stim_state, range);
	endfunction

	function automatic exec_pkg::data_t rand_word();
		exec_pkg::data_t w;
		w[31:16] = 16'(rnd(65536));
		w[15:0] = 16'(rnd(65536));
		return w;
	endfunction

	function automatic exec_pkg::data_t fill_word(input exec_pkg::addr_t a);
		return {~a, a} ^ 32'h9e37_79b9;
	endfunction

	function automatic exec_pkg::data_t expected_alu(input exec_pkg::op_t o,
			input exec_pkg::data_t a, input exec_pkg::data_t b);
		case (o)
			exec_pkg::OP_ADD:	return a + b;
			exec_pkg::OP_SUB:	return a - b;
			exec_pkg::OP_AND:	return a & b;
			exec_pkg::OP_XOR:	return a ^ b;
			exec_pkg::OP_SHL:	return a << b[4:0];
			default:			return '0;
		endcase
	endfunction

	task automatic report_mismatch(input string what, input exec_pkg::data_t exp,
			input exec_pkg::data_t act);
		$display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
		errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("Failure in %s: %s", cur_test, msg);
		errors++;
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	task automatic record_issue(input exec_pkg::op_t o, input exec_pkg::index_t d,
			input exec_pkg::data_t a, input exec_pkg::data_t b);
		int i;
		int lane;
		logic mem_op;
		i = issue_cnt;
		lane = a[0];
		mem_op = (o == exec_pkg::OP_LOAD) || (o == exec_pkg::OP_STORE);
		seq_cnt++;
		issue_cnt++;										// Wraps like the DUT counter
		if (mem_op)
			sent_ldst[lane]++;
		if (o == exec_pkg::OP_STORE) begin
			shadow[a[15:0]] = b;
		end else begin
			assert (!pend[i])
				else report_problem($sformatf("issue number %0d reused while pending", i));
			pend[i] = 1'b1;
			npend++;
			exp_dst[i] = d;
			exp_seq[i] = seq_cnt;
			exp_src[i] = mem_op ? 1 + lane : 0;
			exp_data[i] = (o == exec_pkg::OP_LOAD) ? shadow[a[15:0]] : expected_alu(o, a, b);
		end
	endtask

	// Sequence number of the oldest result still owed by a source
	function automatic int oldest_pending(input int src);
		int best;
		best = 0;
		for (int i = 0; i < 64; i++)
			if (pend[i] && exp_src[i] == src && (best == 0 || exp_seq[i] < best))
				best = exp_seq[i];
		return best;
	endfunction

	task automatic check_writeback();
		int i;
		i = wb_issue_no;
		assert (pend[i])
			else report_problem($sformatf("write-back with issue number %0d not pending", i));
		if (pend[i]) begin
			assert (wb_dst == exp_dst[i]) else report_mismatch("dst", exp_dst[i], wb_dst);
			assert (wb_data == exp_data[i]) else report_mismatch("data", exp_data[i], wb_data);
			assert (exp_seq[i] > last_seq[exp_src[i]])
				else report_problem($sformatf("issue %0d written back out of order", i));
			// A loaded result waiting in another lane must be younger
			for (int l = 0; l < exec_pkg::LANES; l++) begin
				if (load_ready[l] && exp_src[i] != 1 + l) begin
					assert (load_seq[l] > exp_seq[i])
						else report_problem($sformatf(
							"issue %0d written back before an older load on lane %0d", i, l));
				end
			end
			if (exp_src[i] > 0)
				load_ready[exp_src[i] - 1] = 1'b0;
			last_seq[exp_src[i]] = exp_seq[i];
			pend[i] = 1'b0;
			npend--;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Wishbone bank models
	////////////////////////////////////////////////////////////
	always @(negedge clock) begin
		for (int l = 0; l < exec_pkg::LANES; l++) begin
			if (wb_ack[l]) begin
				wb_ack[l] = 1'b0;							// Ack cycle just ended
				active[l] = 1'b0;
				bus_done[l]++;
				if (wb_we[l])
					bank[l][wb_adr[l]] = wb_dat_w[l];
			end else if (wb_cyc[l] && wb_stb[l]) begin
				if (!active[l]) begin
					active[l] = 1'b1;
					wait_left[l] = hold_mode ? 6 + lcg_step(mem_state, 4) : lcg_step(mem_state, 4);
				end
				if (wait_left[l] == 0) begin
					wb_ack[l] = 1'b1;
					wb_dat_r[l] = bank[l][wb_adr[l]];
				end else begin
					wait_left[l]--;
				end
			end
		end
	end

	// Bus protocol and write-back monitor
	always @(posedge clock) begin
		if (!rst) begin
			if (wb_valid)
				check_writeback();							// Before this edge's acks are noted
			for (int l = 0; l < exec_pkg::LANES; l++) begin
				if (wb_cyc[l])
					assert (wb_adr[l][0] == l[0])
						else report_problem($sformatf("lane %0d active for wrong address bit", l));
				if (prev_wait[l])
					assert (wb_stb[l] && wb_adr[l] == prev_adr[l] && wb_dat_w[l] == prev_dat[l])
						else report_problem($sformatf("lane %0d request changed before ack", l));
				if (wb_cyc[l] && !prev_cyc[l])
					bus_starts[l]++;
				if (wb_cyc[l] && wb_ack[l] && !wb_we[l]) begin
					load_ready[l] = 1'b1;					// Result valid from the next cycle
					load_seq[l] = oldest_pending(1 + l);
				end
				prev_wait[l] = wb_stb[l] && !wb_ack[l];
				prev_cyc[l] = wb_cyc[l];
				prev_adr[l] = wb_adr[l];
				prev_dat[l] = wb_dat_w[l];
			end
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles with %0d results outstanding", cycles, npend);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	task automatic send(input exec_pkg::op_t o, input exec_pkg::index_t d,
			input exec_pkg::data_t a, input exec_pkg::data_t b);
		int gap;
		gap = rnd(gap_max + 1);
		repeat (gap) begin
			@(negedge clock);
			req = 1'b0;
		end
		@(negedge clock);
		req = 1'b1;
		op = o;
		dst = d;
		src_a = a;
		src_b = b;
		@(posedge clock);
		while (!ready) begin								// Held until accepted
			stalls++;
			@(posedge clock);
		end
		record_issue(o, d, a, b);
	endtask

	task automatic send_random(input exec_pkg::op_t o, input int addr_span);
		exec_pkg::index_t d;
		exec_pkg::data_t a;
		exec_pkg::data_t b;
		d = exec_pkg::index_t'(rnd(16));
		a = rand_word();
		b = rand_word();
		if (o == exec_pkg::OP_LOAD || o == exec_pkg::OP_STORE)
			a[15:0] = 16'h0040 + 16'(rnd(addr_span));		// Small window so loads hit stores
		send(o, d, a, b);
	endtask

	function automatic logic all_done();
		logic done;
		done = (npend == 0);
		for (int l = 0; l < exec_pkg::LANES; l++)
			done = done && (bus_done[l] == sent_ldst[l]);
		return done;
	endfunction

	task automatic finish_test(input int errors_before);
		@(negedge clock);
		req = 1'b0;
		while (!all_done())
			@(negedge clock);
		for (int l = 0; l < exec_pkg::LANES; l++)
			assert (bus_starts[l] == sent_ldst[l])
				else report_mismatch($sformatf("lane %0d bus cycles", l), sent_ldst[l], bus_starts[l]);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s passed", cur_test);
		end else begin
			$display("test %s failed with %0d errors", cur_test, errors - errors_before);
			tests_failed++;
		end
	endtask

	initial begin
		int t0;
		exec_pkg::op_t o;
		rst = 1'b1;
		req = 1'b0;
		op = exec_pkg::OP_ADD;
		dst = '0;
		src_a = '0;
		src_b = '0;
		hold_mode = 1'b0;
		gap_max = 2;
		{stalls, errors, tests_run, tests_failed, cycles, seq_cnt, npend} = '0;
		issue_cnt = '0;
		for (int i = 0; i < 64; i++)
			pend[i] = 1'b0;
		for (int s = 0; s < exec_pkg::NSRC; s++)
			last_seq[s] = 0;
		for (int l = 0; l < exec_pkg::LANES; l++) begin
			wb_ack[l] = 1'b0;
			wb_dat_r[l] = '0;
			{sent_ldst[l], bus_done[l], bus_starts[l], wait_left[l], load_seq[l]} = '0;
			{active[l], prev_wait[l], prev_cyc[l], load_ready[l]} = '0;
		end
		for (int a = 0; a < 65536; a++) begin
			shadow[a] = fill_word(exec_pkg::addr_t'(a));
			for (int l = 0; l < exec_pkg::LANES; l++)
				bank[l][a] = shadow[a];
		end
		repeat (2) @(negedge clock);
		rst = 1'b0;

		cur_test = "reset";
		t0 = errors;
		@(negedge clock);
		assert (ready) else report_mismatch("ready", 1, ready);
		assert (!wb_valid) else report_mismatch("wb_valid", 0, wb_valid);
		for (int l = 0; l < exec_pkg::LANES; l++)
			assert (!wb_cyc[l] && !wb_stb[l])
				else report_mismatch($sformatf("lane %0d cyc and stb", l), 0, {wb_cyc[l], wb_stb[l]});
		finish_test(t0);

		cur_test = "alu";
		t0 = errors;
		repeat (100) begin
			o = exec_pkg::op_t'(rnd(5));
			send_random(o, 1);
		end
		finish_test(t0);

		cur_test = "load_after_store";
		t0 = errors;
		repeat (24) send_random(exec_pkg::OP_STORE, 8);
		repeat (24) send_random(exec_pkg::OP_LOAD, 8);
		finish_test(t0);

		cur_test = "mixed";
		t0 = errors;
		repeat (150) begin
			o = exec_pkg::op_t'(rnd(7));
			send_random(o, 32);
		end
		finish_test(t0);

		cur_test = "back_pressure";
		t0 = errors;
		hold_mode = 1'b1;									// Ack withheld 6 to 9 cycles
		gap_max = 0;
		stalls = 0;
		repeat (30) begin
			o = (rnd(4) == 0) ? exec_pkg::op_t'(rnd(5)) : exec_pkg::op_t'(5 + rnd(2));
			send_random(o, 16);
		end
		assert (stalls > 0) else report_problem("ready never dropped while ack was withheld");
		finish_test(t0);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* sources.f */
src/exec_pkg.sv
src/exec_dispatch.sv
src/exec_alu.sv
src/ldst_lane.sv
src/wb_select.sv
src/exec_unit.sv
verif/tb_exec_unit.sv
